// ==== Makefile ====
# Verilator build and run of the trap unit testbench.
TOP := trap_unit_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== csr_file.sv ====
// Machine mode only; mip reads the latched lines, and mtval, delegation and mstatush read 0.
`timescale 1ns/10ps
`include "trap_params.svh"

module csr_file import trap_pkg::*; #(
    // Value reported by mhartid.
    parameter word_t hart_id = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  csr_req_t    csr_req,
    output csr_rsp_t    csr_rsp,
    input  trap_event_t trap_event,
    input  logic        mret,
    input  word_t       irq_pending,
    output word_t       mie,
    output logic        mstatus_mie,
    output tvec_t       mtvec,
    output pc_t         mepc,
    output word_t       misa
);
    // Previous interrupt enable.
    logic   mstatus_mpie;
    // Scratch register.
    word_t  mscratch;
    // Cause split into interrupt flag and number.
    logic   mcause_int;
    cause_t mcause_no;
    // Enabled extensions, only the optional ones.
    logic   misa_a;
    logic   misa_c;
    logic   misa_m;

    // Assembled read views.
    word_t  mstatus_rd;
    word_t  mcause_rd;

    // A trap or interrupt enters this cycle.
    logic   trap_entry;

    assign trap_entry = trap_event.take_irq | trap_event.take_trap;

    // mstatus has MIE at bit 3 and MPIE at bit 7.
    always_comb begin
        mstatus_rd    = '0;
        mstatus_rd[3] = mstatus_mie;
        mstatus_rd[7] = mstatus_mpie;
    end

    // Interrupt flag on top, number at the bottom.
    always_comb begin
        mcause_rd      = '0;
        mcause_rd[31]  = mcause_int;
        mcause_rd[4:0] = mcause_no;
    end

    // misa.
    // MXL of 01 means 32-bit; I is always present.
    always_comb begin
        misa              = '0;
        misa[31:30]       = 2'b01;
        misa[`MISA_BIT_I] = 1'b1;
        misa[`MISA_BIT_A] = misa_a;
        misa[`MISA_BIT_C] = misa_c;
        misa[`MISA_BIT_M] = misa_m;
    end

    // Read decode.
    always_comb begin
        csr_rsp        = '0;
        csr_rsp.exists = 1'b1;
        case (csr_req.addr)
            `CSR_MSTATUS:    csr_rsp.rdata = mstatus_rd;
            `CSR_MISA:       csr_rsp.rdata = misa;
            `CSR_MEDELEG:    csr_rsp.rdata = '0;
            `CSR_MIDELEG:    csr_rsp.rdata = '0;
            `CSR_MIE:        csr_rsp.rdata = mie;
            `CSR_MTVEC:      csr_rsp.rdata = {mtvec, 2'b00};
            `CSR_MSTATUSH:   csr_rsp.rdata = '0;
            `CSR_MSCRATCH:   csr_rsp.rdata = mscratch;
            `CSR_MEPC:       csr_rsp.rdata = {mepc, 1'b0};
            `CSR_MCAUSE:     csr_rsp.rdata = mcause_rd;
            `CSR_MTVAL:      csr_rsp.rdata = '0;
            `CSR_MIP:        csr_rsp.rdata = irq_pending;
            `CSR_MVENDORID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = '0;
            end
            `CSR_MARCHID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = `MARCHID_VALUE;
            end
            `CSR_MIMPID: begin
                // Version 1.4.0, divider latency field of 2.
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = `MIMPID_VALUE;
            end
            `CSR_MHARTID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = hart_id;
            end
            `CSR_MCONFIGPTR: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = '0;
            end
            default: begin
                // Unknown address.
                csr_rsp.exists = 1'b0;
            end
        endcase
    end

    // Updates.
    // Trap entry first, then a CSR write, then mret.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mepc         <= '0;
            mscratch     <= '0;
            mcause_int   <= 1'b0;
            mcause_no    <= '0;
            // Start with every supported extension on.
            misa_a       <= `HAS_A;
            misa_c       <= `HAS_C;
            misa_m       <= `HAS_M;
        end else if (trap_entry) begin
            // Save state, mask interrupts.
            mepc         <= trap_event.epc;
            mcause_int   <= trap_event.take_irq;
            mcause_no    <= trap_event.cause;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (csr_req.we) begin
            case (csr_req.addr)
                `CSR_MSTATUS: begin
                    mstatus_mie  <= csr_req.wdata[3];
                    mstatus_mpie <= csr_req.wdata[7];
                end
                `CSR_MISA: begin
                    // Unsupported extensions stay off.
                    if (`MISA_WRITABLE) begin
                        misa_a <= `HAS_A & csr_req.wdata[`MISA_BIT_A];
                        misa_c <= `HAS_C & csr_req.wdata[`MISA_BIT_C];
                        misa_m <= `HAS_M & csr_req.wdata[`MISA_BIT_M];
                    end
                end
                `CSR_MIE:      mie      <= csr_req.wdata;
                `CSR_MTVEC:    mtvec    <= csr_req.wdata[31:2];
                `CSR_MSCRATCH: mscratch <= csr_req.wdata;
                `CSR_MEPC:     mepc     <= csr_req.wdata[31:1];
                `CSR_MCAUSE: begin
                    mcause_int <= csr_req.wdata[31];
                    mcause_no  <= csr_req.wdata[4:0];
                end
                default: begin
                    // Read-only or unknown, nothing stored.
                end
            endcase
        end else if (mret) begin
            // Return restores the saved enable.
            mstatus_mie <= mstatus_mpie;
        end
    end

    // The retiring instruction cannot be a trap and an mret.
    assert property (@(posedge clk) disable iff (rst)
        !(trap_entry && mret))
        else $error("csr_file: trap entry during mret");

    // A write to a read-only CSR leaves every stored CSR as it was.
    assert property (@(posedge clk) disable iff (rst)
        (csr_req.we && csr_rsp.exists && csr_rsp.rdonly && !trap_entry)
        |=> ($stable(mstatus_rd) && $stable(mie) && $stable(mtvec) && $stable(mepc)
            && $stable(mscratch) && $stable(mcause_rd) && $stable(misa)))
        else $error("csr_file: write to a read-only CSR changed state");

endmodule

// ==== exception_ctrl.sv ====
// Interrupt lines must be synchronous to clk; an interrupt is only taken on a valid retire.
`timescale 1ns/10ps
`include "trap_params.svh"

module exception_ctrl import trap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ext_irq_t    ext_irq,
    input  logic        timer_irq,
    input  retire_t     retire,
    input  word_t       mie,
    input  logic        mstatus_mie,
    input  tvec_t       mtvec,
    output trap_event_t trap_event,
    output word_t       irq_pending,
    output logic        exception,
    output tvec_t       tvec
);
    // Depth of the MIE history.
    localparam int hist_len = `MIE_HISTORY;

    // Pending bits that are also enabled.
    word_t                  irq_masked;
    // Lowest enabled pending index.
    cause_t                 irq_cause;
    // Past values of mstatus.MIE, newest in bit 0.
    logic [hist_len-1:0]    mie_hist;
    // MIE is 1 now and has been for the whole history.
    logic                   irq_enable;

    // Latch the interrupt lines.
    // A line high at an edge is pending from the next cycle on.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
        end else begin
            irq_pending                 <= '0;
            irq_pending[31:16]          <= ext_irq;
            irq_pending[`TIMER_IRQ_BIT] <= timer_irq;
        end
    end

    assign irq_masked = irq_pending & mie;

    // Fixed priority.
    // Scan downwards so the lowest set index is the last one written.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

    // Shift history of mstatus.MIE.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= (mie_hist << 1) | hist_len'(mstatus_mie);
        end
    end

    // Interrupts wait until MIE has settled.
    assign irq_enable = mstatus_mie && (&mie_hist);

    // Dispatch.
    // An interrupt beats the trap of the same retiring instruction.
    always_comb begin
        trap_event     = '0;
        trap_event.epc = retire.pc;
        if (irq_cause != '0 && irq_enable && retire.valid) begin
            // Interrupt taken.
            trap_event.take_irq = 1'b1;
            trap_event.cause    = irq_cause;
        end else if (retire.trap) begin
            // Synchronous trap.
            trap_event.take_trap = 1'b1;
            trap_event.cause     = retire.cause;
        end
    end

    // Flush strobe and vector, same cycle.
    assign exception = trap_event.take_irq | trap_event.take_trap;
    assign tvec      = mtvec;

    // Never an interrupt and a trap at once.
    assert property (@(posedge clk) disable iff (rst)
        !(trap_event.take_irq && trap_event.take_trap))
        else $error("exception_ctrl: interrupt and trap taken together");

    // An interrupt implies MIE was set at the two previous edges.
    assert property (@(posedge clk) disable iff (rst)
        trap_event.take_irq |-> ($past(mstatus_mie, 1) && $past(mstatus_mie, 2)))
        else $error("exception_ctrl: interrupt taken before MIE settled");

endmodule

// ==== list.f ====
+incdir+.
trap_pkg.sv
exception_ctrl.sv
csr_file.sv
machine_trap_unit.sv
trap_unit_tb.sv

// ==== machine_trap_unit.sv ====
// Top of the trap and CSR unit; the caller must flush on exception and redirect fetch to tvec.
`timescale 1ns/10ps

module machine_trap_unit import trap_pkg::*; #(
    // Value reported by mhartid.
    parameter word_t hart_id = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  ext_irq_t    ext_irq,
    input  logic        timer_irq,
    input  retire_t     retire,
    input  logic        mret,
    input  csr_req_t    csr_req,
    output csr_rsp_t    csr_rsp,
    output logic        exception,
    output tvec_t       tvec,
    output pc_t         ret_epc,
    output word_t       misa
);
    // Trap event into the CSR file.
    trap_event_t    trap_event;
    // Latched pending lines, also the mip read.
    word_t          irq_pending;
    // CSR state fed back to the dispatcher.
    word_t          mie;
    logic           mstatus_mie;
    tvec_t          mtvec;

    // Interrupt latch, priority and dispatch.
    exception_ctrl u_exception_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ext_irq     (ext_irq),
        .timer_irq   (timer_irq),
        .retire      (retire),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .trap_event  (trap_event),
        .irq_pending (irq_pending),
        .exception   (exception),
        .tvec        (tvec)
    );

    // Machine CSRs.
    // mepc doubles as the return address for mret.
    csr_file #(
        .hart_id (hart_id)
    ) u_csr_file (
        .clk         (clk),
        .rst         (rst),
        .csr_req     (csr_req),
        .csr_rsp     (csr_rsp),
        .trap_event  (trap_event),
        .mret        (mret),
        .irq_pending (irq_pending),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .mepc        (ret_epc),
        .misa        (misa)
    );

endmodule

// ==== trap_params.svh ====
// Machine-mode only; misa writes touch A, C and M, and only when the extension is built in.
`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

// Machine CSR addresses.
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MEDELEG     12'h302
`define CSR_MIDELEG     12'h303
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSTATUSH    12'h310
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344
`define CSR_MVENDORID   12'hf11
`define CSR_MARCHID     12'hf12
`define CSR_MIMPID      12'hf13
`define CSR_MHARTID     12'hf14
`define CSR_MCONFIGPTR  12'hf15

// Extension letters in misa.
`define MISA_BIT_A      0
`define MISA_BIT_C      2
`define MISA_BIT_I      8
`define MISA_BIT_M      12

// Identification values.
`define MARCHID_VALUE   32'd37
`define MIMPID_VALUE    ((32'd2 << 16) | (32'd1 << 8) | (32'd4 << 4) | 32'd0)

// Built-in extensions and misa write support.
`define HAS_M           1'b1
`define HAS_A           1'b1
`define HAS_C           1'b1
`define MISA_WRITABLE   1'b1

// Interrupt layout and enable history depth.
`define TIMER_IRQ_BIT   7
`define MIE_HISTORY     2

`endif

// ==== trap_pkg.sv ====
// Widths assume RV32 with 16 platform interrupt lines mapped to mip bits 31 to 16.
package trap_pkg;

    // Full data word.
    typedef logic [31:0] word_t;

    // Halfword-aligned address, bit 0 is implied zero.
    typedef logic [31:1] pc_t;

    // Word-aligned trap vector.
    typedef logic [31:2] tvec_t;

    // CSR address.
    typedef logic [11:0] csr_addr_t;

    // Trap or interrupt number.
    typedef logic [4:0] cause_t;

    // Platform interrupt lines.
    typedef logic [31:16] ext_irq_t;

    // One CSR access.
    typedef struct packed {
        logic       we;
        csr_addr_t  addr;
        word_t      wdata;
    } csr_req_t;

    // Answer to a CSR access.
    typedef struct packed {
        logic   exists;
        logic   rdonly;
        word_t  rdata;
    } csr_rsp_t;

    // Instruction leaving the pipeline.
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        logic   trap;
        cause_t cause;
    } retire_t;

    // Trap or interrupt being taken this cycle.
    typedef struct packed {
        logic   take_irq;
        logic   take_trap;
        cause_t cause;
        pc_t    epc;
    } trap_event_t;

endpackage

// ==== trap_unit_tb_tasks.svh ====
// Included inside trap_unit_tb; tasks start and end on a falling edge and use its signals directly.
`ifndef TRAP_UNIT_TB_TASKS_SVH
`define TRAP_UNIT_TB_TASKS_SVH

// All inputs quiet.
task automatic idle_inputs();
    ext_irq   = '0;
    timer_irq = 1'b0;
    retire    = '0;
    mret      = 1'b0;
    csr_req   = '0;
endtask

// Typed compares.
task automatic word_equals(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch at time %0t: %s got %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic tvec_equals(input string name, input tvec_t got, input tvec_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch at time %0t: %s got %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic flag_equals(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Mismatch at time %0t: %s got %b, expected %b", $time, name, got, exp);
    end
endtask

// Per-test bookkeeping.
task automatic open_test();
    errors_at_start = error_count;
    test_count++;
endtask

task automatic close_test(input string name);
    if (error_count == errors_at_start) begin
        $display("%s: ok", name);
    end else begin
        failed_tests++;
        $display("%s: failed with %0d errors", name, error_count - errors_at_start);
    end
endtask

// Expected misa; m_on is the last value written to M.
function automatic word_t expected_misa(input logic m_on);
    word_t v;
    v                 = '0;
    v[31:30]          = 2'b01;
    v[`MISA_BIT_I]    = 1'b1;
    v[`MISA_BIT_A]    = `HAS_A;
    v[`MISA_BIT_C]    = `HAS_C;
    v[`MISA_BIT_M]    = `HAS_M & m_on;
    return v;
endfunction

// Combinational read sampled mid low phase.
task automatic read_csr(input csr_addr_t addr, output csr_rsp_t rsp);
    @(negedge clk);
    csr_req.we    = 1'b0;
    csr_req.addr  = addr;
    csr_req.wdata = '0;
    #1;
    rsp = csr_rsp;
endtask

task automatic read_and_compare(input csr_addr_t addr, input string name, input word_t exp);
    csr_rsp_t rsp;
    read_csr(addr, rsp);
    word_equals(name, rsp.rdata, exp);
endtask

// Write commits at the rising edge in between.
task automatic write_csr(input csr_addr_t addr, input word_t data);
    @(negedge clk);
    csr_req.we    = 1'b1;
    csr_req.addr  = addr;
    csr_req.wdata = data;
    @(negedge clk);
    csr_req.we    = 1'b0;
endtask

// One retiring instruction with a trap; flush and vector in the same cycle.
task automatic take_trap(input word_t pc_addr, input cause_t cause, input word_t vec);
    @(negedge clk);
    retire.valid = 1'b1;
    retire.pc    = pc_addr[31:1];
    retire.trap  = 1'b1;
    retire.cause = cause;
    #1;
    flag_equals("exception", exception, 1'b1);
    tvec_equals("tvec", tvec, vec[31:2]);
    @(negedge clk);
    retire = '0;
endtask

// Bounded wait for the flush strobe.
task automatic wait_exception(input int limit);
    int   waited;
    logic seen;
    waited = 0;
    seen   = exception;
    while (!seen && waited < limit) begin
        @(negedge clk);
        #1;
        seen = exception;
        waited++;
    end
    if (!seen) begin
        error_count++;
        $display("Timeout at time %0t: exception did not rise within %0d cycles", $time, limit);
    end
endtask

task automatic reset_and_identity();
    csr_rsp_t rsp;
    open_test();
    flag_equals("exception", exception, 1'b0);
    read_and_compare(`CSR_MARCHID, "marchid", `MARCHID_VALUE);
    read_and_compare(`CSR_MHARTID, "mhartid", hart_id);
    read_and_compare(`CSR_MIMPID, "mimpid", `MIMPID_VALUE);
    read_and_compare(`CSR_MISA, "misa", expected_misa(1'b1));
    word_equals("misa port", misa, expected_misa(1'b1));
    read_and_compare(`CSR_MIE, "mie", '0);
    read_and_compare(`CSR_MTVEC, "mtvec", '0);
    read_and_compare(`CSR_MEPC, "mepc", '0);
    read_and_compare(`CSR_MCAUSE, "mcause", '0);
    read_and_compare(`CSR_MSTATUS, "mstatus", '0);
    // Custom range is not decoded.
    read_csr(12'h7c0, rsp);
    flag_equals("exists", rsp.exists, 1'b0);
    read_csr(`CSR_MVENDORID, rsp);
    flag_equals("rdonly", rsp.rdonly, 1'b1);
    // Write to an ID register is dropped.
    write_csr(`CSR_MARCHID, '1);
    read_and_compare(`CSR_MARCHID, "marchid after write", `MARCHID_VALUE);
    close_test("reset_and_identity");
endtask

task automatic masked_writeback();
    open_test();
    write_csr(`CSR_MTVEC, '1);
    read_and_compare(`CSR_MTVEC, "mtvec", 32'hffff_fffc);
    write_csr(`CSR_MEPC, '1);
    read_and_compare(`CSR_MEPC, "mepc", 32'hffff_fffe);
    write_csr(`CSR_MCAUSE, '1);
    read_and_compare(`CSR_MCAUSE, "mcause", 32'h8000_001f);
    write_csr(`CSR_MSCRATCH, '1);
    read_and_compare(`CSR_MSCRATCH, "mscratch", 32'hffff_ffff);
    // Only MPIE and MIE stick.
    write_csr(`CSR_MSTATUS, '1);
    read_and_compare(`CSR_MSTATUS, "mstatus", 32'h0000_0088);
    close_test("masked_writeback");
endtask

task automatic synchronous_trap();
    open_test();
    write_csr(`CSR_MTVEC, 32'h0000_1200);
    write_csr(`CSR_MSTATUS, 32'h0000_0008);
    take_trap(32'h0000_4a6e, 5'd11, 32'h0000_1200);
    read_and_compare(`CSR_MEPC, "mepc", 32'h0000_4a6e);
    read_and_compare(`CSR_MCAUSE, "mcause", 32'h0000_000b);
    // MIE saved into MPIE, then cleared.
    read_and_compare(`CSR_MSTATUS, "mstatus", 32'h0000_0080);
    close_test("synchronous_trap");
endtask

task automatic interrupt_priority();
    word_t irq_pc;
    irq_pc = 32'h0000_6000;
    open_test();
    write_csr(`CSR_MIE, (32'd1 << `TIMER_IRQ_BIT) | (32'd1 << 17) | (32'd1 << 20));
    write_csr(`CSR_MSTATUS, 32'h0000_0008);
    // Let MIE settle.
    repeat (3) @(negedge clk);
    ext_irq[17]  = 1'b1;
    ext_irq[20]  = 1'b1;
    timer_irq    = 1'b1;
    retire.valid = 1'b1;
    retire.pc    = irq_pc[31:1];
    #1;
    // Lines are not latched yet.
    flag_equals("exception", exception, 1'b0);
    wait_exception(10);
    @(negedge clk);
    idle_inputs();
    // Timer has the lowest index.
    read_and_compare(`CSR_MCAUSE, "mcause", 32'h8000_0000 | `TIMER_IRQ_BIT);
    read_and_compare(`CSR_MEPC, "mepc", irq_pc);
    // All enables off, lines ignored.
    write_csr(`CSR_MIE, '0);
    write_csr(`CSR_MSTATUS, 32'h0000_0008);
    repeat (3) @(negedge clk);
    ext_irq      = '1;
    timer_irq    = 1'b1;
    retire.valid = 1'b1;
    repeat (20) begin
        #1;
        flag_equals("exception", exception, 1'b0);
        @(negedge clk);
    end
    idle_inputs();
    close_test("interrupt_priority");
endtask

task automatic mret_return();
    word_t trap_pc;
    trap_pc = 32'h0000_2468;
    open_test();
    write_csr(`CSR_MTVEC, 32'h0000_2000);
    write_csr(`CSR_MSTATUS, 32'h0000_0008);
    take_trap(trap_pc, 5'd2, 32'h0000_2000);
    read_and_compare(`CSR_MSTATUS, "mstatus", 32'h0000_0080);
    @(negedge clk);
    mret = 1'b1;
    #1;
    flag_equals("exception", exception, 1'b0);
    @(negedge clk);
    mret = 1'b0;
    // MIE back from MPIE.
    read_and_compare(`CSR_MSTATUS, "mstatus", 32'h0000_0088);
    word_equals("ret_epc", {ret_epc, 1'b0}, trap_pc);
    close_test("mret_return");
endtask

task automatic misa_update();
    word_t no_m;
    word_t after_clear;
    open_test();
    no_m                 = expected_misa(1'b1);
    no_m[`MISA_BIT_M]    = 1'b0;
    // M only drops when misa is writable.
    after_clear          = `MISA_WRITABLE ? expected_misa(1'b0) : expected_misa(1'b1);
    write_csr(`CSR_MISA, no_m);
    read_and_compare(`CSR_MISA, "misa", after_clear);
    word_equals("misa port", misa, after_clear);
    write_csr(`CSR_MISA, expected_misa(1'b1));
    read_and_compare(`CSR_MISA, "misa", expected_misa(1'b1));
    word_equals("misa port", misa, expected_misa(1'b1));
    close_test("misa_update");
endtask

`endif

// ==== trap_unit_tb.sv ====
// Directed testbench; hart_id is fixed at 3 and all inputs change on the falling edge.
`timescale 1ns/10ps
`include "trap_params.svh"

module trap_unit_tb import trap_pkg::*; ();
    // Hart number given to the DUT.
    localparam word_t hart_id = 32'd3;

    // DUT ports.
    logic       clk;
    logic       rst;
    ext_irq_t   ext_irq;
    logic       timer_irq;
    retire_t    retire;
    logic       mret;
    csr_req_t   csr_req;
    csr_rsp_t   csr_rsp;
    logic       exception;
    tvec_t      tvec;
    pc_t        ret_epc;
    word_t      misa;

    // Run statistics.
    int         check_count;
    int         error_count;
    int         test_count;
    int         failed_tests;
    // Error count when the current test began.
    int         errors_at_start;

    machine_trap_unit #(
        .hart_id (hart_id)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .ext_irq   (ext_irq),
        .timer_irq (timer_irq),
        .retire    (retire),
        .mret      (mret),
        .csr_req   (csr_req),
        .csr_rsp   (csr_rsp),
        .exception (exception),
        .tvec      (tvec),
        .ret_epc   (ret_epc),
        .misa      (misa)
    );

    `include "trap_unit_tb_tasks.svh"

    // 8 ns clock.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Test sequence.
    initial begin
        check_count     = 0;
        error_count     = 0;
        test_count      = 0;
        failed_tests    = 0;
        errors_at_start = 0;
        rst             = 1'b1;
        idle_inputs();
        // Ten rising edges in reset, released on a falling edge.
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_and_identity();
        masked_writeback();
        synchronous_trap();
        interrupt_priority();
        mret_return();
        misa_update();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
